/* common/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Datapath and register file sizes
`define MIPS_WORD_W       32
`define MIPS_REG_AW       5
`define MIPS_REG_COUNT    32

// First fetch address and syscall drain depth
`define MIPS_RESET_PC     32'h0000_0000
`define MIPS_DRAIN_CYCLES 2

`endif

/* common/mipsPkg.sv */
`include "mips_macros.svh"

package mipsPkg;

    typedef logic [`MIPS_WORD_W-1:0] wordT;
    typedef logic [`MIPS_REG_AW-1:0] regAddrT;

    // --------------------
    // Instruction encodings
    // --------------------
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opBeq     = 6'h04,
        opAddiu   = 6'h09,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeT;

    // Function field of SPECIAL instructions
    typedef enum logic [5:0] {
        fnSyscall = 6'h0c,
        fnAddu    = 6'h21,
        fnSubu    = 6'h23,
        fnAnd     = 6'h24,
        fnOr      = 6'h25,
        fnSlt     = 6'h2a
    } functT;

    // --------------------
    // Internal encodings
    // --------------------
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    // Syscall sequencing
    typedef enum logic [1:0] {
        stRun,
        stDrain,
        stHalted
    } ctrlStateT;

endpackage

/* common/pipeBus.sv */
`timescale 1ns/1ns

// Decode to execute stage register
interface idExBus;
    mipsPkg::aluOpT   aluOp;
    mipsPkg::wordT    operandA;
    mipsPkg::wordT    operandB;
    mipsPkg::wordT    storeData;
    mipsPkg::regAddrT writeReg;
    logic             regWrite;
    logic             memRead;
    logic             memWrite;
    logic             isBranch;
    mipsPkg::wordT    branchTarget;

    modport driver (
        output aluOp, operandA, operandB, storeData, writeReg, regWrite,
               memRead, memWrite, isBranch, branchTarget
    );
    modport receiver (
        input  aluOp, operandA, operandB, storeData, writeReg, regWrite,
               memRead, memWrite, isBranch, branchTarget
    );
endinterface

// Execute to memory stage register
interface exMemBus;
    mipsPkg::wordT    aluResult;
    mipsPkg::wordT    storeData;
    mipsPkg::regAddrT writeReg;
    logic             regWrite;
    logic             memRead;
    logic             memWrite;

    modport driver   (output aluResult, storeData, writeReg, regWrite, memRead, memWrite);
    modport receiver (input  aluResult, storeData, writeReg, regWrite, memRead, memWrite);
    // Decode only needs the pending destination for hazard checks
    modport monitor  (input  writeReg, regWrite);
endinterface

/* src/fetchUnit.sv */
`timescale 1ns/1ns
`include "mips_macros.svh"

module fetchUnit (
    input  logic          clk,
    input  logic          arstN,
    input  logic          hazardStall,
    input  logic          freeze,
    input  logic          redirect,
    input  mipsPkg::wordT redirectPc,
    output mipsPkg::wordT instrAddress
);

    mipsPkg::wordT pc;

    // Taken branch wins over any hold
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `MIPS_RESET_PC;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!(hazardStall || freeze)) begin
            pc <= pc + mipsPkg::wordT'(4);
        end
    end

    assign instrAddress = pc;

endmodule

/* decode/regFile.sv */
`timescale 1ns/1ns
`include "mips_macros.svh"

module regFile (
    input  logic             clk,
    input  logic             arstN,
    input  mipsPkg::regAddrT readRegA,
    input  mipsPkg::regAddrT readRegB,
    input  mipsPkg::regAddrT wbReg,
    input  mipsPkg::wordT    wbData,
    input  logic             wbEn,
    output mipsPkg::wordT    readDataA,
    output mipsPkg::wordT    readDataB
);

    mipsPkg::wordT regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (wbReg != '0)) begin
            regs[wbReg] <= wbData;
        end
    end

    // $zero is hardwired, a same-cycle write is passed through
    assign readDataA = (readRegA == '0) ? '0 :
                       (wbEn && (wbReg == readRegA)) ? wbData : regs[readRegA];
    assign readDataB = (readRegB == '0) ? '0 :
                       (wbEn && (wbReg == readRegB)) ? wbData : regs[readRegB];

endmodule

/* decode/decodeStage.sv */
`timescale 1ns/1ns
`include "mips_macros.svh"

module decodeStage (
    input  logic             clk,
    input  logic             arstN,
    input  mipsPkg::wordT    instr,
    input  mipsPkg::wordT    instrAddress,
    input  logic             redirect,
    input  logic             freeze,
    input  mipsPkg::regAddrT wbReg,
    input  mipsPkg::wordT    wbData,
    input  logic             wbEn,
    output logic             hazardStall,
    output logic             sysSeen,
    idExBus.driver           idEx,
    exMemBus.monitor         exMem
);

    mipsPkg::wordT    ifIdInstr;
    mipsPkg::wordT    ifIdPc;
    mipsPkg::regAddrT rs;
    mipsPkg::regAddrT rt;
    mipsPkg::regAddrT rd;
    mipsPkg::wordT    immExt;
    mipsPkg::wordT    rsData;
    mipsPkg::wordT    rtData;
    mipsPkg::aluOpT   aluOp;
    logic             useImm;
    logic             useRs;
    logic             useRt;
    logic             destIsRd;
    logic             regWrite;
    logic             memRead;
    logic             memWrite;
    logic             isBranch;
    logic             isSys;
    logic             hazA;
    logic             hazB;
    logic             bubble;

    // --------------------
    // IF/ID register
    // --------------------
    // Flushed to all zeros, which decodes as nothing
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ifIdInstr <= '0;
        end else if (redirect) begin
            ifIdInstr <= '0;
        end else if (!(hazardStall || freeze)) begin
            ifIdInstr <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!(hazardStall || freeze)) begin
            ifIdPc <= instrAddress;
        end
    end

    // --------------------
    // Field decode
    // --------------------
    assign rs     = ifIdInstr[25:21];
    assign rt     = ifIdInstr[20:16];
    assign rd     = ifIdInstr[15:11];
    assign immExt = {{(`MIPS_WORD_W-16){ifIdInstr[15]}}, ifIdInstr[15:0]};

    always_comb begin
        aluOp    = mipsPkg::aluAdd;
        useImm   = 1'b0;
        useRs    = 1'b0;
        useRt    = 1'b0;
        destIsRd = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        isBranch = 1'b0;
        isSys    = 1'b0;
        case (mipsPkg::opcodeT'(ifIdInstr[31:26]))
            mipsPkg::opSpecial: begin
                // Common R-type controls, cleared again for unknown functs
                useRs    = 1'b1;
                useRt    = 1'b1;
                destIsRd = 1'b1;
                regWrite = 1'b1;
                case (mipsPkg::functT'(ifIdInstr[5:0]))
                    mipsPkg::fnAddu: aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: aluOp = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   aluOp = mipsPkg::aluOr;
                    mipsPkg::fnSlt:  aluOp = mipsPkg::aluSlt;
                    mipsPkg::fnSyscall: begin
                        useRs    = 1'b0;
                        useRt    = 1'b0;
                        regWrite = 1'b0;
                        isSys    = 1'b1;
                    end
                    default: begin
                        useRs    = 1'b0;
                        useRt    = 1'b0;
                        regWrite = 1'b0;
                    end
                endcase
            end
            mipsPkg::opAddiu: begin
                useRs    = 1'b1;
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            mipsPkg::opLw: begin
                useRs    = 1'b1;
                useImm   = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            mipsPkg::opSw: begin
                useRs    = 1'b1;
                useRt    = 1'b1;
                useImm   = 1'b1;
                memWrite = 1'b1;
            end
            mipsPkg::opBeq: begin
                useRs    = 1'b1;
                useRt    = 1'b1;
                isBranch = 1'b1;
            end
            default: ;
        endcase
    end

    regFile uRegFile (
        .clk       (clk),
        .arstN     (arstN),
        .readRegA  (rs),
        .readRegB  (rt),
        .wbReg     (wbReg),
        .wbData    (wbData),
        .wbEn      (wbEn),
        .readDataA (rsData),
        .readDataB (rtData)
    );

    // --------------------
    // RAW hazards
    // --------------------
    // Producers in execute or memory are not yet visible in the register file
    assign hazA = useRs && (rs != '0) &&
                  ((idEx.regWrite && (idEx.writeReg == rs)) ||
                   (exMem.regWrite && (exMem.writeReg == rs)));
    assign hazB = useRt && (rt != '0) &&
                  ((idEx.regWrite && (idEx.writeReg == rt)) ||
                   (exMem.regWrite && (exMem.writeReg == rt)));

    assign hazardStall = hazA || hazB;
    assign sysSeen     = isSys && !redirect && !freeze;
    assign bubble      = hazardStall || redirect || freeze || isSys;

    // --------------------
    // ID/EX register
    // --------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx.regWrite <= 1'b0;
            idEx.memRead  <= 1'b0;
            idEx.memWrite <= 1'b0;
            idEx.isBranch <= 1'b0;
        end else begin
            idEx.regWrite <= regWrite && !bubble;
            idEx.memRead  <= memRead && !bubble;
            idEx.memWrite <= memWrite && !bubble;
            idEx.isBranch <= isBranch && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        idEx.aluOp        <= aluOp;
        idEx.operandA     <= rsData;
        idEx.operandB     <= useImm ? immExt : rtData;
        idEx.storeData    <= rtData;
        idEx.writeReg     <= destIsRd ? rd : rt;
        idEx.branchTarget <= ifIdPc + mipsPkg::wordT'(4) + (immExt << 2);
    end

endmodule

/* src/executeStage.sv */
`timescale 1ns/1ns

module executeStage (
    input  logic          clk,
    input  logic          arstN,
    output logic          redirect,
    output mipsPkg::wordT redirectPc,
    idExBus.receiver      idEx,
    exMemBus.driver       exMem
);

    mipsPkg::wordT aluResult;

    // Loads and stores reach here as aluAdd with the offset in operandB
    always_comb begin
        case (idEx.aluOp)
            mipsPkg::aluAdd: aluResult = idEx.operandA + idEx.operandB;
            mipsPkg::aluSub: aluResult = idEx.operandA - idEx.operandB;
            mipsPkg::aluAnd: aluResult = idEx.operandA & idEx.operandB;
            mipsPkg::aluOr:  aluResult = idEx.operandA | idEx.operandB;
            mipsPkg::aluSlt: begin
                aluResult = mipsPkg::wordT'($signed(idEx.operandA) < $signed(idEx.operandB));
            end
            default: aluResult = '0;
        endcase
    end

    // BEQ resolves here, younger instructions get flushed by fetch and decode
    assign redirect   = idEx.isBranch && (idEx.operandA == idEx.operandB);
    assign redirectPc = idEx.branchTarget;

    // --------------------
    // EX/MEM register
    // --------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exMem.regWrite <= 1'b0;
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
        end else begin
            exMem.regWrite <= idEx.regWrite;
            exMem.memRead  <= idEx.memRead;
            exMem.memWrite <= idEx.memWrite;
        end
    end

    always_ff @(posedge clk) begin
        exMem.aluResult <= aluResult;
        exMem.storeData <= idEx.storeData;
        exMem.writeReg  <= idEx.writeReg;
    end

endmodule

/* src/memoryStage.sv */
`timescale 1ns/1ns

module memoryStage (
    input  logic             clk,
    input  logic             arstN,
    input  mipsPkg::wordT    readData,
    output mipsPkg::wordT    dataAddress,
    output mipsPkg::wordT    writeData,
    output logic             memRead,
    output logic             memWrite,
    output mipsPkg::regAddrT wbReg,
    output mipsPkg::wordT    wbData,
    output logic             wbEn,
    exMemBus.receiver        exMem
);

    // Data memory answers in the same cycle
    assign dataAddress = exMem.aluResult;
    assign writeData   = exMem.storeData;
    assign memRead     = exMem.memRead;
    assign memWrite    = exMem.memWrite;

    // --------------------
    // MEM/WB register
    // --------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbEn <= 1'b0;
        end else begin
            wbEn <= exMem.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbReg  <= exMem.writeReg;
        wbData <= exMem.memRead ? readData : exMem.aluResult;
    end

endmodule

/* src/pipelineControl.sv */
`timescale 1ns/1ns
`include "mips_macros.svh"

module pipelineControl (
    input  logic clk,
    input  logic arstN,
    input  logic sysSeen,
    output logic freeze,
    output logic sys
);

    localparam int CountW = $clog2(`MIPS_DRAIN_CYCLES + 1);
    localparam logic [CountW-1:0] LastCount = CountW'(`MIPS_DRAIN_CYCLES - 1);

    mipsPkg::ctrlStateT state;
    logic [CountW-1:0]  drainCount;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state      <= mipsPkg::stRun;
            drainCount <= '0;
        end else begin
            case (state)
                mipsPkg::stRun: begin
                    if (sysSeen) begin
                        state      <= mipsPkg::stDrain;
                        drainCount <= '0;
                    end
                end
                mipsPkg::stDrain: begin
                    // let execute and memory empty out
                    if (drainCount == LastCount) begin
                        state <= mipsPkg::stHalted;
                    end else begin
                        drainCount <= drainCount + 1'b1;
                    end
                end
                mipsPkg::stHalted: ;
                default: state <= mipsPkg::stRun;
            endcase
        end
    end

    assign freeze = (state != mipsPkg::stRun);
    assign sys    = (state == mipsPkg::stHalted);

endmodule

/* src/mipsCore.sv */
`timescale 1ns/1ns

module mipsCore (
    input  logic          clk,
    input  logic          arstN,
    output mipsPkg::wordT instrAddress,
    input  mipsPkg::wordT instr,
    output mipsPkg::wordT dataAddress,
    output logic          memRead,
    output logic          memWrite,
    output mipsPkg::wordT writeData,
    input  mipsPkg::wordT readData,
    output logic          sys
);

    logic             redirect;
    mipsPkg::wordT    redirectPc;
    logic             hazardStall;
    logic             sysSeen;
    logic             freeze;
    mipsPkg::regAddrT wbReg;
    mipsPkg::wordT    wbData;
    logic             wbEn;

    idExBus  idEx ();
    exMemBus exMem ();

    fetchUnit uFetch (
        .clk          (clk),
        .arstN        (arstN),
        .hazardStall  (hazardStall),
        .freeze       (freeze),
        .redirect     (redirect),
        .redirectPc   (redirectPc),
        .instrAddress (instrAddress)
    );

    decodeStage uDecode (
        .clk          (clk),
        .arstN        (arstN),
        .instr        (instr),
        .instrAddress (instrAddress),
        .redirect     (redirect),
        .freeze       (freeze),
        .wbReg        (wbReg),
        .wbData       (wbData),
        .wbEn         (wbEn),
        .hazardStall  (hazardStall),
        .sysSeen      (sysSeen),
        .idEx         (idEx.driver),
        .exMem        (exMem.monitor)
    );

    executeStage uExecute (
        .clk        (clk),
        .arstN      (arstN),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .idEx       (idEx.receiver),
        .exMem      (exMem.driver)
    );

    memoryStage uMemory (
        .clk         (clk),
        .arstN       (arstN),
        .readData    (readData),
        .dataAddress (dataAddress),
        .writeData   (writeData),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .wbReg       (wbReg),
        .wbData      (wbData),
        .wbEn        (wbEn),
        .exMem       (exMem.receiver)
    );

    pipelineControl uControl (
        .clk     (clk),
        .arstN   (arstN),
        .sysSeen (sysSeen),
        .freeze  (freeze),
        .sys     (sys)
    );

endmodule

/* bench/mipsCoreTb.sv */
`timescale 1ns/1ns
`include "mips_macros.svh"

module mipsCoreTb;

    localparam int ProgLen       = 25;
    localparam int ResetCycles   = 8;
    localparam int ExpStores     = 8;
    localparam int ExpLoads      = 2;
    localparam int HoldCycles    = 6;
    localparam int TimeoutCycles = ProgLen * 4 + ResetCycles + 20;

    logic          clk;
    logic          arstN;
    mipsPkg::wordT instrAddress;
    mipsPkg::wordT instr;
    mipsPkg::wordT dataAddress;
    logic          memRead;
    logic          memWrite;
    mipsPkg::wordT writeData;
    mipsPkg::wordT readData;
    logic          sys;

    mipsPkg::wordT imem [32];
    mipsPkg::wordT dmem [64];
    mipsPkg::wordT expAddr [ExpStores];
    mipsPkg::wordT expData [ExpStores];
    mipsPkg::wordT expLoadAddr [ExpLoads];
    mipsPkg::wordT storeAddrLog [$];
    mipsPkg::wordT storeDataLog [$];
    mipsPkg::wordT loadAddrLog [$];
    integer        seed;
    int            cycleCount;
    int            wordErrors;
    int            flagErrors;
    int            countErrors;

    mipsCore DUT (
        .clk          (clk),
        .arstN        (arstN),
        .instrAddress (instrAddress),
        .instr        (instr),
        .dataAddress  (dataAddress),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .writeData    (writeData),
        .readData     (readData),
        .sys          (sys)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------
    // Memory models
    // --------------------
    // Both answer in the same cycle
    // Fetches past the end of the program read zero
    assign instr    = (instrAddress < mipsPkg::wordT'(ProgLen * 4)) ?
                      imem[instrAddress[6:2]] : '0;
    assign readData = dmem[dataAddress[7:2]];

    always @(posedge clk) begin
        if (memWrite) begin
            storeAddrLog.push_back(dataAddress);
            storeDataLog.push_back(writeData);
        end
        if (memRead) begin
            loadAddrLog.push_back(dataAddress);
        end
    end

    // --------------------
    // Encoding and checks
    // --------------------
    function automatic mipsPkg::wordT encodeR(mipsPkg::functT fn, mipsPkg::regAddrT rs,
                                              mipsPkg::regAddrT rt, mipsPkg::regAddrT rd);
        return {mipsPkg::opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mipsPkg::wordT encodeI(mipsPkg::opcodeT op, mipsPkg::regAddrT rs,
                                              mipsPkg::regAddrT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic checkWord(string name, mipsPkg::wordT actual, mipsPkg::wordT expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            wordErrors++;
        end
    endtask

    task automatic checkFlag(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            flagErrors++;
        end
    endtask

    task automatic checkCount(string name, int actual, int expected);
        if (actual != expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            countErrors++;
        end
    endtask

    task automatic checkResetState();
        checkFlag("memWrite", memWrite, 1'b0);
        checkFlag("memRead", memRead, 1'b0);
        checkFlag("sys", sys, 1'b0);
        checkWord("instrAddress", instrAddress, `MIPS_RESET_PC);
    endtask

    // --------------------
    // Program and expected stores
    // --------------------
    task automatic loadProgram();
        for (int i = 0; i < 32; i++) begin
            imem[i] = '0;
        end
        imem[0]  = encodeI(mipsPkg::opLw, 5'd0, 5'd1, 16'h0010);
        imem[1]  = encodeI(mipsPkg::opLw, 5'd0, 5'd2, 16'h0014);
        // Load followed by its use
        imem[2]  = encodeR(mipsPkg::fnAddu, 5'd1, 5'd2, 5'd3);
        imem[3]  = encodeI(mipsPkg::opSw, 5'd0, 5'd3, 16'h0040);
        imem[4]  = encodeR(mipsPkg::fnSubu, 5'd1, 5'd2, 5'd4);
        imem[5]  = encodeI(mipsPkg::opSw, 5'd0, 5'd4, 16'h0044);
        imem[6]  = encodeR(mipsPkg::fnAnd, 5'd1, 5'd2, 5'd5);
        imem[7]  = encodeI(mipsPkg::opSw, 5'd0, 5'd5, 16'h0048);
        imem[8]  = encodeR(mipsPkg::fnOr, 5'd1, 5'd2, 5'd6);
        imem[9]  = encodeI(mipsPkg::opSw, 5'd0, 5'd6, 16'h004c);
        imem[10] = encodeR(mipsPkg::fnSlt, 5'd1, 5'd2, 5'd7);
        imem[11] = encodeI(mipsPkg::opSw, 5'd0, 5'd7, 16'h0050);
        imem[12] = encodeI(mipsPkg::opAddiu, 5'd1, 5'd8, 16'hfff0);
        imem[13] = encodeI(mipsPkg::opSw, 5'd0, 5'd8, 16'h0054);
        imem[14] = encodeI(mipsPkg::opAddiu, 5'd0, 5'd9, 16'h7777);
        // Taken branch to 18 skips two sentinel stores
        imem[15] = encodeI(mipsPkg::opBeq, 5'd1, 5'd1, 16'h0002);
        imem[16] = encodeI(mipsPkg::opSw, 5'd0, 5'd9, 16'h0058);
        imem[17] = encodeI(mipsPkg::opSw, 5'd0, 5'd9, 16'h005c);
        // Not taken since r9 is nonzero
        imem[18] = encodeI(mipsPkg::opBeq, 5'd0, 5'd9, 16'h0001);
        imem[19] = encodeI(mipsPkg::opSw, 5'd0, 5'd9, 16'h0060);
        imem[20] = encodeI(mipsPkg::opAddiu, 5'd9, 5'd10, 16'h0001);
        imem[21] = encodeI(mipsPkg::opSw, 5'd0, 5'd10, 16'h0064);
        imem[22] = encodeR(mipsPkg::fnSyscall, 5'd0, 5'd0, 5'd0);
        // Nothing behind the syscall may store
        imem[23] = encodeI(mipsPkg::opSw, 5'd0, 5'd9, 16'h0068);
        imem[24] = encodeI(mipsPkg::opSw, 5'd0, 5'd9, 16'h006c);
    endtask

    task automatic expectStore(int idx, mipsPkg::wordT addr, mipsPkg::wordT data);
        expAddr[idx] = addr;
        expData[idx] = data;
    endtask

    task automatic buildExpected();
        mipsPkg::wordT a;
        mipsPkg::wordT b;
        a = dmem[4];
        b = dmem[5];
        expectStore(0, 32'h40, a + b);
        expectStore(1, 32'h44, a - b);
        expectStore(2, 32'h48, a & b);
        expectStore(3, 32'h4c, a | b);
        expectStore(4, 32'h50, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        expectStore(5, 32'h54, a + 32'hffff_fff0);
        expectStore(6, 32'h60, 32'h0000_7777);
        expectStore(7, 32'h64, 32'h0000_7778);
        // The two operand loads
        expLoadAddr[0] = 32'h10;
        expLoadAddr[1] = 32'h14;
    endtask

    // --------------------
    // Timeout
    // --------------------
    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the core did not halt within %0d cycles", TimeoutCycles);
        $display("Errors: %0d word, %0d flag, %0d count", wordErrors, flagErrors, countErrors);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        arstN       = 1'b0;
        wordErrors  = 0;
        flagErrors  = 0;
        countErrors = 0;
        seed        = 32'h14b;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = $random(seed);
        end
        loadProgram();
        buildExpected();

        repeat (ResetCycles) begin
            @(negedge clk);
            checkResetState();
        end
        @(posedge clk);
        arstN <= 1'b1;
        // First cycle out of reset
        @(negedge clk);
        checkResetState();

        while (!sys) begin
            @(negedge clk);
        end
        repeat (HoldCycles) begin
            @(negedge clk);
            checkFlag("sys", sys, 1'b1);
            checkFlag("memWrite", memWrite, 1'b0);
        end

        checkCount("store count", storeAddrLog.size(), ExpStores);
        for (int i = 0; i < ExpStores && i < storeAddrLog.size(); i++) begin
            checkWord($sformatf("store address %0d", i), storeAddrLog[i], expAddr[i]);
            checkWord($sformatf("store data %0d", i), storeDataLog[i], expData[i]);
        end

        checkCount("load count", loadAddrLog.size(), ExpLoads);
        for (int i = 0; i < ExpLoads && i < loadAddrLog.size(); i++) begin
            checkWord($sformatf("load address %0d", i), loadAddrLog[i], expLoadAddr[i]);
        end

        $display("Errors: %0d word, %0d flag, %0d count", wordErrors, flagErrors, countErrors);
        if (wordErrors + flagErrors + countErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+common
common/mipsPkg.sv
common/pipeBus.sv
src/fetchUnit.sv
decode/regFile.sv
decode/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/pipelineControl.sv
src/mipsCore.sv
bench/mipsCoreTb.sv

/* run.sh */
#!/bin/sh
# Build the simulation with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module mipsCoreTb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/VmipsCoreTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Test OK" "$LOG"; then
    echo "No result found in $LOG"
    exit 1
fi
exit 0
